//--- axi_perf.f
+incdir+include
verilog/axi_perf_bus_pkg.sv
verilog/axi_perf_ctrl_pkg.sv
verilog/axi_perf_regs.sv
verilog/axi_perf_wr_gen.sv
verilog/axi_perf_wr_arbiter.sv
verilog/axi_perf_wr_stats.sv
verilog/axi_perf.sv
verification/axi_wr_mem_model.sv
verification/axi_perf_tb.sv

//--- verification/axi_perf_tb.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_tb;
  import axi_perf_bus_pkg::*;
  import axi_perf_ctrl_pkg::*;

  localparam int RUN_READS = 3000;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_wr;
  logic                   reg_rd;
  logic [`REG_ADDR_W-1:0] reg_addr;
  logic [`REG_DATA_W-1:0] reg_wdata;
  logic                   reg_ack;
  logic                   reg_err;
  logic [`REG_DATA_W-1:0] reg_rdata;
  axi_aw_t                m_aw;
  logic                   m_awvalid;
  logic                   m_awready;
  axi_w_t                 m_w;
  logic                   m_wvalid;
  logic                   m_wready;
  axi_b_t                 m_b;
  logic                   m_bvalid;
  logic                   m_bready;
  logic                   bp_en;
  logic                   err_en;
  logic [`AXI_ADDR_W-1:0] err_addr;
  gen_cfg_t               cfg [`NUM_GEN];

  axi_perf u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_reg_wr   (reg_wr),
    .i_reg_rd   (reg_rd),
    .i_reg_addr (reg_addr),
    .i_reg_wdata(reg_wdata),
    .o_reg_ack  (reg_ack),
    .o_reg_err  (reg_err),
    .o_reg_rdata(reg_rdata),
    .o_m_aw     (m_aw),
    .o_m_awvalid(m_awvalid),
    .i_m_awready(m_awready),
    .o_m_w      (m_w),
    .o_m_wvalid (m_wvalid),
    .i_m_wready (m_wready),
    .i_m_b      (m_b),
    .i_m_bvalid (m_bvalid),
    .o_m_bready (m_bready)
  );

  axi_wr_mem_model u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_bp_en   (bp_en),
    .i_err_en  (err_en),
    .i_err_addr(err_addr),
    .i_aw      (m_aw),
    .i_awvalid (m_awvalid),
    .o_awready (m_awready),
    .i_w       (m_w),
    .i_wvalid  (m_wvalid),
    .o_wready  (m_wready),
    .o_b       (m_b),
    .o_bvalid  (m_bvalid),
    .i_bready  (m_bready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [`REG_DATA_W-1:0] expected,
                            input logic [`REG_DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_aw(input string name, input axi_aw_t expected, input axi_aw_t actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_w(input string name, input axi_w_t expected, input axi_w_t actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  // ------------------------------
  // register access
  // ------------------------------
  function automatic logic [`REG_ADDR_W-1:0] word_addr(input int idx);
    return `REG_ADDR_W'(idx * 4);
  endfunction

  // called on a falling edge with the ack due one cycle later
  task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr,
                           input logic [`REG_DATA_W-1:0] data, input logic exp_err);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
    check_flag("o_reg_ack", 1'b1, reg_ack);
    check_flag("o_reg_err", exp_err, reg_err);
  endtask

  task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr, input logic exp_err,
                          output logic [`REG_DATA_W-1:0] data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_rd = 1'b0;
    check_flag("o_reg_ack", 1'b1, reg_ack);
    check_flag("o_reg_err", exp_err, reg_err);
    data = reg_rdata;
  endtask

  task automatic expect_reg(input string name, input logic [`REG_ADDR_W-1:0] addr,
                            input logic [`REG_DATA_W-1:0] expected);
    logic [`REG_DATA_W-1:0] val;
    read_reg(addr, 1'b0, val);
    check_word(name, expected, val);
  endtask

  function automatic gen_cfg_t make_cfg(input logic [`AXI_ADDR_W-1:0] base,
                                        input logic [7:0] beats,
                                        input logic [`AXI_ADDR_W-1:0] stride,
                                        input logic [15:0] num, input logic [2:0] size);
    gen_cfg_t c;
    c.base_addr    = base;
    c.burst_beats  = beats;
    c.burst_stride = stride;
    c.burst_num    = num;
    c.burst_size   = size;
    return c;
  endfunction

  task automatic configure_gen(input int g, input gen_cfg_t c);
    int blk;
    blk    = 8 * g;
    cfg[g] = c;
    write_reg(word_addr(int'(REG_GEN_BASE) + blk), 32'(c.base_addr), 1'b0);
    write_reg(word_addr(int'(REG_GEN_BEATS) + blk), 32'(c.burst_beats), 1'b0);
    write_reg(word_addr(int'(REG_GEN_STRIDE) + blk), 32'(c.burst_stride), 1'b0);
    write_reg(word_addr(int'(REG_GEN_NUM) + blk), 32'(c.burst_num), 1'b0);
    write_reg(word_addr(int'(REG_GEN_SIZE) + blk), 32'(c.burst_size), 1'b0);
    expect_reg("GEN_NUM", word_addr(int'(REG_GEN_NUM) + blk), 32'(c.burst_num));
  endtask

  // counters drop to zero one edge after the clear pulse
  task automatic clear_stats();
    write_reg(word_addr(REG_CLEAR), 32'd1, 1'b0);
    @(negedge clk);
  endtask

  task automatic run_and_wait();
    logic [`REG_DATA_W-1:0] val;
    bit                     done;
    u_mem.clear_log();
    write_reg(word_addr(REG_START), 32'd1, 1'b0);
    expect_reg("REG_START", word_addr(REG_START), 32'd1);
    done = 1'b0;
    for (int i = 0; i < RUN_READS && !done; i++) begin
      read_reg(word_addr(REG_IDLE), 1'b0, val);
      done = (val == 32'd1);
    end
    if (!done) begin
      $display("timeout: REG_IDLE did not read 1 within %0d reads after start", RUN_READS);
      stop_run();
    end
  endtask

  // walk the port log burst by burst against each source's own rule
  task automatic verify_traffic();
    int      n_aw;
    int      n_w;
    int      wp;
    int      k;
    int      src;
    int      seen [`NUM_GEN];
    axi_aw_t got_aw;
    axi_aw_t exp_aw;
    axi_w_t  exp_w;
    n_aw = u_mem.aw_count();
    n_w  = u_mem.w_count();
    wp   = 0;
    foreach (seen[g]) begin
      seen[g] = 0;
    end
    for (int i = 0; i < n_aw; i++) begin
      got_aw = u_mem.aw_at(i);
      src    = int'(got_aw.id[`AXI_ID_W-1]);
      k      = seen[src];
      if (k >= int'(cfg[src].burst_num)) begin
        $display("more bursts seen from generator %0d than it was given", src);
        stop_run();
      end
      exp_aw.addr  = cfg[src].base_addr + `AXI_ADDR_W'(k) * cfg[src].burst_stride;
      exp_aw.id    = `AXI_ID_W'(src) << `GEN_ID_W;
      exp_aw.len   = cfg[src].burst_beats - 8'd1;
      exp_aw.size  = cfg[src].burst_size;
      exp_aw.burst = BURST_INCR;
      check_aw("o_m_aw", exp_aw, got_aw);
      for (int j = 0; j < int'(cfg[src].burst_beats); j++) begin
        if (wp >= n_w) begin
          $display("write data ended before burst %0d of generator %0d was complete", k, src);
          stop_run();
        end
        exp_w.data = `AXI_DATA_W'(k * 256 + j);
        exp_w.strb = '1;
        exp_w.last = (j == int'(cfg[src].burst_beats) - 1);
        check_w("o_m_w", exp_w, u_mem.w_at(wp));
        wp++;
      end
      seen[src]++;
    end
    for (int g = 0; g < `NUM_GEN; g++) begin
      check_word("bursts per generator", 32'(cfg[g].burst_num), 32'(seen[g]));
    end
    check_word("W beat count", 32'(wp), 32'(n_w));
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_identity();
    logic [`REG_DATA_W-1:0] val;
    check_flag("o_m_awvalid", 1'b0, m_awvalid);
    check_flag("o_m_wvalid", 1'b0, m_wvalid);
    check_flag("o_reg_ack", 1'b0, reg_ack);
    expect_reg("REG_IDLE", word_addr(REG_IDLE), 32'd1);
    expect_reg("REG_NUM_GEN", word_addr(REG_NUM_GEN), 32'd2);
    expect_reg("REG_CLK_FREQ", word_addr(REG_CLK_FREQ), 32'd100000000);
    @(negedge clk);
    check_flag("o_reg_ack", 1'b0, reg_ack);
    check_flag("o_m_bready", 1'b1, m_bready);
    // unaligned start, read-only and unmapped writes
    write_reg(8'h01, 32'd1, 1'b1);
    write_reg(word_addr(REG_IDLE), 32'd0, 1'b1);
    write_reg(word_addr(5), 32'd0, 1'b1);
    write_reg(word_addr(REG_STAT_AW), 32'd0, 1'b1);
    read_reg(word_addr(6), 1'b1, val);
    check_word("o_reg_rdata", 32'd0, val);
    read_reg(word_addr(int'(REG_GEN_SIZE) + 1), 1'b1, val);
    check_word("o_reg_rdata", 32'd0, val);
    expect_reg("REG_IDLE", word_addr(REG_IDLE), 32'd1);
  endtask

  task automatic single_gen_run();
    bp_en = 1'b0;
    configure_gen(0, make_cfg(20'h01000, 8'd4, 20'h00040, 16'd3, 3'd1));
    configure_gen(1, make_cfg(20'h03000, 8'd2, 20'h00010, 16'd0, 3'd1));
    run_and_wait();
    check_word("AW count", 32'd3, 32'(u_mem.aw_count()));
    check_word("W count", 32'd12, 32'(u_mem.w_count()));
    verify_traffic();
  endtask

  task automatic dual_gen_backpressure();
    bp_en = 1'b1;
    configure_gen(0, make_cfg(20'h02000, 8'd3, 20'h00100, 16'd4, 3'd1));
    configure_gen(1, make_cfg(20'h80000, 8'd5, 20'h00020, 16'd3, 3'd1));
    run_and_wait();
    verify_traffic();
  endtask

  task automatic stats_run();
    int                     sum_num;
    int                     sum_beats;
    logic [`REG_DATA_W-1:0] busy;
    bp_en = 1'b1;
    configure_gen(0, make_cfg(20'h10000, 8'd4, 20'h00040, 16'd5, 3'd1));
    configure_gen(1, make_cfg(20'h20000, 8'd2, 20'h00010, 16'd6, 3'd1));
    clear_stats();
    run_and_wait();
    sum_num   = 0;
    sum_beats = 0;
    for (int g = 0; g < `NUM_GEN; g++) begin
      sum_num   += int'(cfg[g].burst_num);
      sum_beats += int'(cfg[g].burst_num) * int'(cfg[g].burst_beats);
    end
    expect_reg("STAT_AW", word_addr(REG_STAT_AW), 32'(sum_num));
    expect_reg("STAT_W", word_addr(REG_STAT_W), 32'(sum_beats));
    expect_reg("STAT_B", word_addr(REG_STAT_B), 32'(sum_num));
    expect_reg("STAT_BERR", word_addr(REG_STAT_BERR), 32'd0);
    read_reg(word_addr(REG_STAT_BUSY), 1'b0, busy);
    check_flag("STAT_BUSY nonzero", 1'b1, busy != '0);
    clear_stats();
    for (int i = 0; i < 5; i++) begin
      expect_reg("STAT after clear", word_addr(int'(REG_STAT_AW) + i), 32'd0);
    end
  endtask

  task automatic error_resp_run();
    bp_en = 1'b0;
    configure_gen(0, make_cfg(20'h04000, 8'd2, 20'h00100, 16'd3, 3'd1));
    configure_gen(1, make_cfg(20'h05000, 8'd2, 20'h00100, 16'd2, 3'd1));
    // second burst of generator 0
    err_addr = cfg[0].base_addr + cfg[0].burst_stride;
    err_en   = 1'b1;
    clear_stats();
    run_and_wait();
    verify_traffic();
    expect_reg("STAT_BERR", word_addr(REG_STAT_BERR), 32'd1);
    expect_reg("STAT_B", word_addr(REG_STAT_B), 32'd5);
    err_en = 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    bp_en     = 1'b0;
    err_en    = 1'b0;
    err_addr  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_identity();
    single_gen_run();
    dual_gen_backpressure();
    stats_run();
    error_resp_run();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- verification/axi_wr_mem_model.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_wr_mem_model (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_bp_en,
  input  logic                      i_err_en,
  input  logic [`AXI_ADDR_W-1:0]    i_err_addr,
  input  axi_perf_bus_pkg::axi_aw_t i_aw,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  axi_perf_bus_pkg::axi_w_t  i_w,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output axi_perf_bus_pkg::axi_b_t  o_b,
  output logic                      o_bvalid,
  input  logic                      i_bready
);
  import axi_perf_bus_pkg::*;

  axi_aw_t    aw_q[$];
  axi_w_t     w_q[$];
  axi_b_t     b_q[$];
  axi_b_t     rsp;
  int         burst_done;
  logic       bp_on;
  logic [7:0] lfsr;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic int aw_count();
    return aw_q.size();
  endfunction

  function automatic int w_count();
    return w_q.size();
  endfunction

  function automatic axi_aw_t aw_at(input int i);
    return aw_q[i];
  endfunction

  function automatic axi_w_t w_at(input int i);
    return w_q[i];
  endfunction

  task automatic clear_log();
    aw_q.delete();
    w_q.delete();
    b_q.delete();
    burst_done = 0;
  endtask

  // ------------------------------
  // accepted traffic
  // ------------------------------
  always @(posedge clk) begin
    bp_on = i_bp_en;
    if (rst_n) begin
      if (i_awvalid && o_awready) begin
        aw_q.push_back(i_aw);
      end
      if (o_bvalid && i_bready && b_q.size() != 0) begin
        b_q.delete(0);
      end
      if (i_wvalid && o_wready) begin
        w_q.push_back(i_w);
        // queue the response once the burst is complete
        if (i_w.last) begin
          rsp.id   = aw_q[burst_done].id;
          rsp.resp = (i_err_en && aw_q[burst_done].addr == i_err_addr) ? SLVERR : OKAY;
          b_q.push_back(rsp);
          burst_done++;
        end
      end
    end
  end

  // ready and response driven on the falling edge
  initial begin
    lfsr       = 8'd95;
    bp_on      = 1'b0;
    burst_done = 0;
    o_awready  = 1'b0;
    o_wready   = 1'b0;
    o_bvalid   = 1'b0;
    o_b        = '0;
    forever begin
      @(negedge clk);
      if (bp_on) begin
        o_awready = lfsr[0];
        lfsr      = lfsr_next(lfsr);
        o_wready  = lfsr[0];
        lfsr      = lfsr_next(lfsr);
      end else begin
        o_awready = 1'b1;
        o_wready  = 1'b1;
      end
      o_bvalid = (b_q.size() != 0);
      o_b      = o_bvalid ? b_q[0] : '0;
    end
  end

endmodule

//--- verilog/axi_perf.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_reg_wr,
  input  logic                      i_reg_rd,
  input  logic [`REG_ADDR_W-1:0]    i_reg_addr,
  input  logic [`REG_DATA_W-1:0]    i_reg_wdata,
  output logic                      o_reg_ack,
  output logic                      o_reg_err,
  output logic [`REG_DATA_W-1:0]    o_reg_rdata,
  output axi_perf_bus_pkg::axi_aw_t o_m_aw,
  output logic                      o_m_awvalid,
  input  logic                      i_m_awready,
  output axi_perf_bus_pkg::axi_w_t  o_m_w,
  output logic                      o_m_wvalid,
  input  logic                      i_m_wready,
  input  axi_perf_bus_pkg::axi_b_t  i_m_b,
  input  logic                      i_m_bvalid,
  output logic                      o_m_bready
);
  import axi_perf_bus_pkg::*;
  import axi_perf_ctrl_pkg::*;

  gen_cfg_t [`NUM_GEN-1:0] gen_cfg;
  logic                    gen_start;
  logic [`NUM_GEN-1:0]     gen_busy;
  logic                    stats_clear;
  logic                    run_active;
  perf_stats_t             stats;

  axi_aw_t [`NUM_GEN-1:0]  gen_aw;
  logic [`NUM_GEN-1:0]     gen_awvalid;
  logic [`NUM_GEN-1:0]     gen_awready;
  axi_w_t [`NUM_GEN-1:0]   gen_w;
  logic [`NUM_GEN-1:0]     gen_wvalid;
  logic [`NUM_GEN-1:0]     gen_wready;
  axi_b_t [`NUM_GEN-1:0]   gen_b;
  logic [`NUM_GEN-1:0]     gen_bvalid;
  logic [`NUM_GEN-1:0]     gen_bready;

  axi_perf_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_reg_wr     (i_reg_wr),
    .i_reg_rd     (i_reg_rd),
    .i_reg_addr   (i_reg_addr),
    .i_reg_wdata  (i_reg_wdata),
    .o_reg_ack    (o_reg_ack),
    .o_reg_err    (o_reg_err),
    .o_reg_rdata  (o_reg_rdata),
    .i_gen_busy   (gen_busy),
    .i_stats      (stats),
    .o_gen_cfg    (gen_cfg),
    .o_gen_start  (gen_start),
    .o_stats_clear(stats_clear),
    .o_run_active (run_active)
  );

  for (genvar g = 0; g < `NUM_GEN; g++) begin : gen_wr
    axi_perf_wr_gen u_gen (
      .clk      (clk),
      .rst_n    (rst_n),
      .i_start  (gen_start),
      .i_cfg    (gen_cfg[g]),
      .o_busy   (gen_busy[g]),
      .o_aw     (gen_aw[g]),
      .o_awvalid(gen_awvalid[g]),
      .i_awready(gen_awready[g]),
      .o_w      (gen_w[g]),
      .o_wvalid (gen_wvalid[g]),
      .i_wready (gen_wready[g]),
      .i_b      (gen_b[g]),
      .i_bvalid (gen_bvalid[g]),
      .o_bready (gen_bready[g])
    );
  end

  axi_perf_wr_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw       (gen_aw),
    .i_awvalid  (gen_awvalid),
    .o_awready  (gen_awready),
    .i_w        (gen_w),
    .i_wvalid   (gen_wvalid),
    .o_wready   (gen_wready),
    .o_b        (gen_b),
    .o_bvalid   (gen_bvalid),
    .i_bready   (gen_bready),
    .o_m_aw     (o_m_aw),
    .o_m_awvalid(o_m_awvalid),
    .i_m_awready(i_m_awready),
    .o_m_w      (o_m_w),
    .o_m_wvalid (o_m_wvalid),
    .i_m_wready (i_m_wready),
    .i_m_b      (i_m_b),
    .i_m_bvalid (i_m_bvalid),
    .o_m_bready (o_m_bready)
  );

  // counts taken at the shared port
  axi_perf_wr_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_clear     (stats_clear),
    .i_run_active(run_active),
    .i_awfire    (o_m_awvalid && i_m_awready),
    .i_wfire     (o_m_wvalid && i_m_wready),
    .i_bfire     (i_m_bvalid && o_m_bready),
    .i_bresp     (i_m_b.resp),
    .o_stats     (stats)
  );

endmodule

//--- verilog/axi_perf_wr_stats.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_wr_stats (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_clear,
  input  logic                           i_run_active,
  input  logic                           i_awfire,
  input  logic                           i_wfire,
  input  logic                           i_bfire,
  input  axi_perf_bus_pkg::axi_resp_e    i_bresp,
  output axi_perf_ctrl_pkg::perf_stats_t o_stats
);
  import axi_perf_bus_pkg::*;
  import axi_perf_ctrl_pkg::*;

  localparam int SW = `STAT_W;

  // holds at all ones
  function automatic logic [SW-1:0] bump(input logic [SW-1:0] cnt, input logic en);
    if (en && cnt != '1) begin
      return cnt + SW'(1);
    end
    return cnt;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      o_stats <= '0;
    end else begin
      o_stats.aw_cnt      <= bump(o_stats.aw_cnt, i_awfire);
      o_stats.w_cnt       <= bump(o_stats.w_cnt, i_wfire);
      o_stats.b_cnt       <= bump(o_stats.b_cnt, i_bfire);
      o_stats.berr_cnt    <= bump(o_stats.berr_cnt, i_bfire && (i_bresp != OKAY));
      o_stats.busy_cycles <= bump(o_stats.busy_cycles, i_run_active);
    end
  end

endmodule

//--- verilog/axi_perf_wr_arbiter.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_wr_arbiter (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  axi_perf_bus_pkg::axi_aw_t [`NUM_GEN-1:0] i_aw,
  input  logic [`NUM_GEN-1:0]                      i_awvalid,
  output logic [`NUM_GEN-1:0]                      o_awready,
  input  axi_perf_bus_pkg::axi_w_t [`NUM_GEN-1:0]  i_w,
  input  logic [`NUM_GEN-1:0]                      i_wvalid,
  output logic [`NUM_GEN-1:0]                      o_wready,
  output axi_perf_bus_pkg::axi_b_t [`NUM_GEN-1:0]  o_b,
  output logic [`NUM_GEN-1:0]                      o_bvalid,
  input  logic [`NUM_GEN-1:0]                      i_bready,
  output axi_perf_bus_pkg::axi_aw_t                o_m_aw,
  output logic                                     o_m_awvalid,
  input  logic                                     i_m_awready,
  output axi_perf_bus_pkg::axi_w_t                 o_m_w,
  output logic                                     o_m_wvalid,
  input  logic                                     i_m_wready,
  input  axi_perf_bus_pkg::axi_b_t                 i_m_b,
  input  logic                                     i_m_bvalid,
  output logic                                     o_m_bready
);
  import axi_perf_bus_pkg::*;

  localparam int GW = `AXI_ID_W - `GEN_ID_W;

  // owner keeps the last grant once its burst ends
  logic [GW-1:0] owner;
  logic [GW-1:0] other;
  logic [GW-1:0] pick;
  logic [GW-1:0] b_sel;
  logic          active;
  logic          aw_sent;
  logic          aw_fire;
  logic          wlast_fire;

  // the other generator goes first when it requests
  assign other      = owner + GW'(1);
  assign pick       = i_awvalid[other] ? other : owner;
  assign aw_fire    = o_m_awvalid && i_m_awready;
  assign wlast_fire = o_m_wvalid && i_m_wready && o_m_w.last;
  assign b_sel      = i_m_b.id[`AXI_ID_W-1:`GEN_ID_W];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active  <= 1'b0;
      aw_sent <= 1'b0;
      owner   <= '0;
    end else if (!active) begin
      if (|i_awvalid) begin
        active  <= 1'b1;
        aw_sent <= 1'b0;
        owner   <= pick;
      end
    end else begin
      if (aw_fire) begin
        aw_sent <= 1'b1;
      end
      if (wlast_fire) begin
        active <= 1'b0;
      end
    end
  end

  // ------------------------------
  // granted burst to the port
  // ------------------------------
  always_comb begin
    o_m_aw      = i_aw[owner];
    o_m_aw.id   = {owner, i_aw[owner].id[`GEN_ID_W-1:0]};
    o_m_awvalid = active && !aw_sent && i_awvalid[owner];
    o_m_w       = i_w[owner];
    o_m_wvalid  = active && aw_sent && i_wvalid[owner];
    o_awready   = '0;
    o_wready    = '0;
    o_awready[owner] = active && !aw_sent && i_m_awready;
    o_wready[owner]  = active && aw_sent && i_m_wready;
  end

  // response routed on the id prefix
  always_comb begin
    o_m_bready = i_bready[b_sel];
    for (int g = 0; g < `NUM_GEN; g++) begin
      o_b[g].id   = {GW'(0), i_m_b.id[`GEN_ID_W-1:0]};
      o_b[g].resp = i_m_b.resp;
      o_bvalid[g] = i_m_bvalid && (b_sel == GW'(g));
    end
  end

endmodule

//--- verilog/axi_perf_wr_gen.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_wr_gen (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_start,
  input  axi_perf_ctrl_pkg::gen_cfg_t i_cfg,
  output logic                        o_busy,
  output axi_perf_bus_pkg::axi_aw_t   o_aw,
  output logic                        o_awvalid,
  input  logic                        i_awready,
  output axi_perf_bus_pkg::axi_w_t    o_w,
  output logic                        o_wvalid,
  input  logic                        i_wready,
  input  axi_perf_bus_pkg::axi_b_t    i_b,
  input  logic                        i_bvalid,
  output logic                        o_bready
);
  import axi_perf_bus_pkg::*;
  import axi_perf_ctrl_pkg::*;

  localparam int DW = `AXI_DATA_W;

  logic [`AXI_ADDR_W-1:0] aw_addr;
  logic [15:0]            aw_cnt;
  logic [15:0]            aw_cnt_next;
  logic [15:0]            w_burst;
  logic [7:0]             w_beat;
  logic [7:0]             last_beat;
  logic [15:0]            b_pend;
  logic [15:0]            b_pend_next;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;

  assign aw_fire     = o_awvalid && i_awready;
  assign w_fire      = o_wvalid && i_wready;
  // the arbiter strips its prefix so our id comes back as 0
  assign b_fire      = i_bvalid && o_bready && (i_b.id == '0);
  assign last_beat   = i_cfg.burst_beats - 8'd1;
  assign aw_cnt_next = aw_cnt + 16'(aw_fire);
  assign b_pend_next = b_pend + 16'(aw_fire) - 16'(b_fire);

  always_comb begin
    o_aw.addr  = aw_addr;
    o_aw.id    = '0;
    o_aw.len   = last_beat;
    o_aw.size  = i_cfg.burst_size;
    o_aw.burst = BURST_INCR;
    // burst index in the high byte, beat index in the low byte
    o_w.data   = DW'({w_burst, w_beat});
    o_w.strb   = '1;
    o_w.last   = (w_beat == last_beat);
  end

  // next burst address
  always_ff @(posedge clk) begin
    if (!o_busy) begin
      aw_addr <= i_cfg.base_addr;
    end else if (aw_fire) begin
      aw_addr <= aw_addr + i_cfg.burst_stride;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_busy    <= 1'b0;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_bready  <= 1'b0;
      aw_cnt    <= '0;
      w_burst   <= '0;
      w_beat    <= '0;
      b_pend    <= '0;
    end else begin
      o_bready <= 1'b1;
      if (!o_busy) begin
        if (i_start) begin
          o_busy    <= 1'b1;
          o_awvalid <= (i_cfg.burst_num != '0);
          o_wvalid  <= (i_cfg.burst_num != '0);
          aw_cnt    <= '0;
          w_burst   <= '0;
          w_beat    <= '0;
          b_pend    <= '0;
        end
      end else begin
        aw_cnt <= aw_cnt_next;
        b_pend <= b_pend_next;
        if (aw_fire) begin
          o_awvalid <= (aw_cnt_next != i_cfg.burst_num);
        end
        if (w_fire && o_w.last) begin
          w_beat   <= '0;
          w_burst  <= w_burst + 16'd1;
          o_wvalid <= (w_burst + 16'd1 != i_cfg.burst_num);
        end else if (w_fire) begin
          w_beat <= w_beat + 8'd1;
        end
        // all bursts issued and every response back
        if (aw_cnt_next == i_cfg.burst_num && b_pend_next == '0) begin
          o_busy <= 1'b0;
        end
      end
    end
  end

endmodule

//--- verilog/axi_perf_regs.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_regs (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       i_reg_wr,
  input  logic                                       i_reg_rd,
  input  logic [`REG_ADDR_W-1:0]                     i_reg_addr,
  input  logic [`REG_DATA_W-1:0]                     i_reg_wdata,
  output logic                                       o_reg_ack,
  output logic                                       o_reg_err,
  output logic [`REG_DATA_W-1:0]                     o_reg_rdata,
  input  logic [`NUM_GEN-1:0]                        i_gen_busy,
  input  axi_perf_ctrl_pkg::perf_stats_t             i_stats,
  output axi_perf_ctrl_pkg::gen_cfg_t [`NUM_GEN-1:0] o_gen_cfg,
  output logic                                       o_gen_start,
  output logic                                       o_stats_clear,
  output logic                                       o_run_active
);
  import axi_perf_ctrl_pkg::*;

  localparam int RDW = `REG_DATA_W;

  run_state_e     state;
  run_state_e     state_next;
  reg_id_e        idx;
  reg_id_e        gen_off;
  logic [2:0]     gen_blk;
  logic [2:0]     gen_sel;
  logic           gen_hit;
  logic           aligned;
  logic           mapped;
  logic           rd_err;
  logic           wr_err;
  logic           wr_ok;
  logic           start_req;
  logic [RDW-1:0] rd_data;

  // ------------------------------
  // address decode
  // ------------------------------
  assign idx     = reg_id_e'(i_reg_addr[`REG_ADDR_W-1:2]);
  assign aligned = (i_reg_addr[1:0] == 2'b00);
  assign gen_blk = i_reg_addr[7:5];
  assign gen_sel = gen_blk - 3'd1;
  assign gen_hit = (gen_blk != 3'd0) && (gen_blk <= 3'(`NUM_GEN));
  // fold any generator block onto the gen 0 names
  assign gen_off = reg_id_e'({3'd1, i_reg_addr[4:2]});

  always_comb begin
    rd_data = '0;
    mapped  = 1'b1;
    if (gen_hit) begin
      case (gen_off)
        REG_GEN_BASE:   rd_data = RDW'(o_gen_cfg[gen_sel].base_addr);
        REG_GEN_BEATS:  rd_data = RDW'(o_gen_cfg[gen_sel].burst_beats);
        REG_GEN_STRIDE: rd_data = RDW'(o_gen_cfg[gen_sel].burst_stride);
        REG_GEN_NUM:    rd_data = RDW'(o_gen_cfg[gen_sel].burst_num);
        REG_GEN_SIZE:   rd_data = RDW'(o_gen_cfg[gen_sel].burst_size);
        default:        mapped  = 1'b0;
      endcase
    end else begin
      case (idx)
        REG_START:     rd_data = RDW'(state != RUN_IDLE);
        REG_IDLE:      rd_data = RDW'(state == RUN_IDLE);
        REG_NUM_GEN:   rd_data = RDW'(`NUM_GEN);
        REG_CLK_FREQ:  rd_data = RDW'(`CLOCK_FREQ);
        REG_CLEAR:     rd_data = RDW'(o_stats_clear);
        REG_STAT_AW:   rd_data = RDW'(i_stats.aw_cnt);
        REG_STAT_W:    rd_data = RDW'(i_stats.w_cnt);
        REG_STAT_B:    rd_data = RDW'(i_stats.b_cnt);
        REG_STAT_BERR: rd_data = RDW'(i_stats.berr_cnt);
        REG_STAT_BUSY: rd_data = RDW'(i_stats.busy_cycles);
        default:       mapped  = 1'b0;
      endcase
    end
  end

  assign rd_err    = !aligned || !mapped;
  // only start, clear and generator config take writes
  assign wr_ok     = gen_hit || (idx == REG_START) || (idx == REG_CLEAR);
  assign wr_err    = rd_err || !wr_ok;
  assign start_req = i_reg_wr && !wr_err && (idx == REG_START) && i_reg_wdata[0];

  // ------------------------------
  // register writes and response
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_gen_cfg     <= '0;
      o_stats_clear <= 1'b0;
      o_reg_ack     <= 1'b0;
    end else begin
      o_reg_ack     <= i_reg_wr || i_reg_rd;
      o_stats_clear <= i_reg_wr && !wr_err && (idx == REG_CLEAR) && i_reg_wdata[0];
      if (i_reg_wr && !wr_err && gen_hit) begin
        case (gen_off)
          REG_GEN_BASE:   o_gen_cfg[gen_sel].base_addr    <= i_reg_wdata[`AXI_ADDR_W-1:0];
          REG_GEN_BEATS:  o_gen_cfg[gen_sel].burst_beats  <= i_reg_wdata[7:0];
          REG_GEN_STRIDE: o_gen_cfg[gen_sel].burst_stride <= i_reg_wdata[`AXI_ADDR_W-1:0];
          REG_GEN_NUM:    o_gen_cfg[gen_sel].burst_num    <= i_reg_wdata[15:0];
          REG_GEN_SIZE:   o_gen_cfg[gen_sel].burst_size   <= i_reg_wdata[2:0];
          default:        o_gen_cfg <= o_gen_cfg;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    o_reg_rdata <= (i_reg_rd && !rd_err) ? rd_data : '0;
    o_reg_err   <= i_reg_rd ? rd_err : wr_err;
  end

  // ------------------------------
  // run state machine
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      RUN_IDLE:  if (start_req) state_next = RUN_START;
      RUN_START: state_next = RUN_WAIT;
      RUN_WAIT:  if (i_gen_busy == '0) state_next = RUN_IDLE;
      default:   state_next = RUN_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RUN_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign o_gen_start  = (state == RUN_START);
  assign o_run_active = (state != RUN_IDLE);

endmodule

//--- verilog/axi_perf_ctrl_pkg.sv
`include "axi_perf_defs.svh"

package axi_perf_ctrl_pkg;

  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_START,
    RUN_WAIT
  } run_state_e;

  // register word index
  // generator blocks repeat every 8 words after the gen 0 block
  typedef enum logic [5:0] {
    REG_START      = 6'd0,
    REG_IDLE       = 6'd1,
    REG_NUM_GEN    = 6'd2,
    REG_CLK_FREQ   = 6'd3,
    REG_CLEAR      = 6'd4,
    REG_GEN_BASE   = 6'd8,
    REG_GEN_BEATS  = 6'd9,
    REG_GEN_STRIDE = 6'd10,
    REG_GEN_NUM    = 6'd11,
    REG_GEN_SIZE   = 6'd12,
    REG_STAT_AW    = 6'd24,
    REG_STAT_W     = 6'd25,
    REG_STAT_B     = 6'd26,
    REG_STAT_BERR  = 6'd27,
    REG_STAT_BUSY  = 6'd28
  } reg_id_e;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] base_addr;
    logic [7:0]             burst_beats;
    logic [`AXI_ADDR_W-1:0] burst_stride;
    logic [15:0]            burst_num;
    logic [2:0]             burst_size;
  } gen_cfg_t;

  typedef struct packed {
    logic [`STAT_W-1:0] aw_cnt;
    logic [`STAT_W-1:0] w_cnt;
    logic [`STAT_W-1:0] b_cnt;
    logic [`STAT_W-1:0] berr_cnt;
    logic [`STAT_W-1:0] busy_cycles;
  } perf_stats_t;

endpackage

//--- verilog/axi_perf_bus_pkg.sv
`include "axi_perf_defs.svh"

package axi_perf_bus_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_ID_W-1:0]   id;
    logic [7:0]             len;
    logic [2:0]             size;
    axi_burst_e             burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axi_resp_e            resp;
  } axi_b_t;

endpackage

//--- include/axi_perf_defs.svh
`ifndef AXI_PERF_DEFS_SVH
`define AXI_PERF_DEFS_SVH

// ------------------------------
// AXI write port
// ------------------------------
`define AXI_ADDR_W 20
`define AXI_DATA_W 16
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_ID_W 4
// top id bit carries the generator index
`define GEN_ID_W (`AXI_ID_W - 1)

// ------------------------------
// engine and register port
// ------------------------------
`define NUM_GEN 2
`define REG_ADDR_W 8
`define REG_DATA_W 32
`define STAT_W 32
`define CLOCK_FREQ 100000000

`endif
